/* verification/divSqrtTrace.txt */
# op loA loB hiA hiB tag trapMask flushAfter expResult expFlags expTrap, all hex
# op 0 divS 1 sqrtS 2 divP 3 sqrtP, flushAfter 0 runs to completion
0 00000064 00000007 00000000 00000000 01 0 00 000000020000000e 2 0
0 00000064 0000000a 00000000 00000000 02 3 00 000000000000000a 0 0
0 00000064 00000007 deadbeef 00000000 03 1 00 000000020000000e 2 0
0 ffffffff 00000010 00000000 00000000 04 2 00 0000000f0fffffff 2 1
0 12345678 00000000 00000000 00000000 05 0 00 12345678ffffffff 3 0
0 12345678 00000000 00000001 00000001 06 1 00 12345678ffffffff 3 1
0 00000000 00000000 00000000 00000000 07 2 00 00000000ffffffff 1 0
0 00000000 00000005 00000000 00000000 08 3 00 0000000000000000 0 0
0 80000000 00000003 00000000 00000000 09 0 00 000000022aaaaaaa 2 0
0 00000007 00000009 00000000 00000000 0a 3 00 0000000700000000 2 1
0 ffffffff ffffffff 00000000 00000000 0b 0 00 0000000000000001 0 0
1 00000064 00000000 00000000 00000000 0c 3 00 000000000000000a 0 0
1 00000065 00000000 00000000 00000000 0d 2 00 000000010000000a 2 1
1 ffffffff 00000000 00000000 00000000 0e 0 00 0001fffe0000ffff 2 0
1 00000000 00000000 00000000 00000000 0f 1 00 0000000000000000 0 0
1 00000002 00000000 00000000 00000000 10 0 00 0000000100000001 2 0
1 40000000 00000000 00000000 00000000 11 3 00 0000000000008000 0 0
1 00000064 00000000 ffffffff 00000000 12 3 00 000000000000000a 0 0
2 00000064 00000007 00000100 00000010 13 0 00 000000100000000e 2 0
2 00000064 0000000a 00000064 00000000 14 1 00 ffffffff0000000a 3 1
2 0000000f 00000005 00001000 00000040 15 3 00 0000004000000003 0 0
2 ffffffff 00000002 00000009 00000003 16 2 00 000000037fffffff 2 1
3 00000064 00000000 00000051 00000000 17 3 00 000000090000000a 0 0
3 00000064 00000000 00000052 00000000 18 2 00 000000090000000a 2 1
3 00000003 00000000 00000010 00000000 19 0 00 0000000400000001 2 0
3 ffffffff 00000000 40000000 00000000 1a 0 00 000080000000ffff 2 0
0 00000064 00000007 00000000 00000000 1b 0 0a 0000000000000000 0 0
0 0000003c 00000008 00000000 00000000 1c 0 00 0000000400000007 2 0
3 00000064 00000000 00000051 00000000 1d 3 05 0000000000000000 0 0
1 00000090 00000000 00000000 00000000 1e 3 00 000000000000000c 0 0
2 ffffffff 00000003 00000064 00000007 1f 3 1e 0000000000000000 0 0
0 000003e8 00000021 00000000 00000000 20 3 00 0000000a0000001e 2 1

/* flist.f */
design/divSqrtOpPkg.sv
design/divSqrtDataPkg.sv
design/divSqrtLane.sv
design/divSqrtCombine.sv
design/divSqrtUnit.sv
verification/divSqrtUnit_sva.sv
verification/divSqrtTb.sv

/* Makefile */
# Verilator build and run of the divide/sqrt unit testbench
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --assert --top-module divSqrtTb -f flist.f --Mdir $(BUILD) -o simv
	./$(BUILD)/simv +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Simulation completed successfully" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* verification/divSqrtTb.sv */
`timescale 1ns/10ps

module divSqrtTb
  import divSqrtOpPkg::*;
  import divSqrtDataPkg::*;
();

  localparam int randOps = 4;

  logic                 clk;
  logic                 rst;
  logic                 flush;
  logic                 en;
  logic [opWidth-1:0]   op;
  logic [tagWidth-1:0]  tag;
  logic [laneWidth-1:0] loA;
  logic [laneWidth-1:0] loB;
  logic [laneWidth-1:0] hiA;
  logic [laneWidth-1:0] hiB;
  logic [flagWidth-1:0] trapMask;
  logic                 busy;
  logic                 outEn;
  logic [resWidth-1:0]  result;
  logic [tagWidth-1:0]  outTag;
  logic [flagWidth-1:0] flags;
  logic                 trap;

  int errors = 0;
  bit traceLoaded = 1'b0;

  // one entry per trace line
  logic [opWidth-1:0]   opQ[$];
  logic [laneWidth-1:0] loAQ[$];
  logic [laneWidth-1:0] loBQ[$];
  logic [laneWidth-1:0] hiAQ[$];
  logic [laneWidth-1:0] hiBQ[$];
  logic [tagWidth-1:0]  tagQ[$];
  logic [flagWidth-1:0] maskQ[$];
  int                   flushQ[$];
  logic [resWidth-1:0]  resQ[$];
  logic [flagWidth-1:0] flagsQ[$];
  logic                 trapQ[$];

  divSqrtUnit divSqrtUnit_inst (
    .clk(clk), .rst(rst), .flush(flush), .en(en), .op(op), .tag(tag),
    .loA(loA), .loB(loB), .hiA(hiA), .hiB(hiB), .trapMask(trapMask),
    .busy(busy), .outEn(outEn), .result(result), .outTag(outTag),
    .flags(flags), .trap(trap)
  );

  bind divSqrtUnit divSqrtUnit_sva sva (
    .clk(clk), .rst(rst), .flush(flush), .busy(busy), .outEn(outEn), .trap(trap)
  );

  always #2 clk = ~clk; // 4 ns period

  // reference lane: plain division and a bitwise search for the floor root
  function automatic void laneModel(
    input  logic                 sqrtOp,
    input  logic [laneWidth-1:0] a,
    input  logic [laneWidth-1:0] b,
    output logic [laneWidth-1:0] q,
    output logic [laneWidth-1:0] r,
    output logic [flagWidth-1:0] f
  );
    logic [63:0] trial;
    int          bitPos;
    if (sqrtOp) begin
      q = '0;
      for (bitPos = rootWidth - 1; bitPos >= 0; bitPos--) begin
        trial = {32'd0, q | (32'd1 << bitPos)};
        if (trial * trial <= {32'd0, a}) q = trial[31:0];
      end
      r = a - q * q;
    end else if (b == '0) begin
      q = '1;
      r = a;
    end else begin
      q = a / b;
      r = a % b;
    end
    f = '0;
    f[flagDivZero] = !sqrtOp && (b == '0);
    f[flagInexact] = r != '0;
  endfunction

  function automatic void unitModel(
    input  logic [opWidth-1:0]   opIn,
    input  logic [laneWidth-1:0] aLo,
    input  logic [laneWidth-1:0] bLo,
    input  logic [laneWidth-1:0] aHi,
    input  logic [laneWidth-1:0] bHi,
    input  logic [flagWidth-1:0] maskIn,
    output logic [resWidth-1:0]  res,
    output logic [flagWidth-1:0] fl,
    output logic                 tr
  );
    logic                 sqrtOp;
    logic                 packedOp;
    logic [laneWidth-1:0] qLo;
    logic [laneWidth-1:0] rLo;
    logic [laneWidth-1:0] qHi;
    logic [laneWidth-1:0] rHi;
    logic [flagWidth-1:0] fLo;
    logic [flagWidth-1:0] fHi;
    sqrtOp   = (opIn == opSqrtS) || (opIn == opSqrtP);
    packedOp = (opIn == opDivP) || (opIn == opSqrtP);
    laneModel(sqrtOp, aLo, bLo, qLo, rLo, fLo);
    laneModel(sqrtOp, aHi, bHi, qHi, rHi, fHi);
    res = packedOp ? {qHi, qLo} : {rLo, qLo};
    fl  = packedOp ? (fLo | fHi) : fLo; // scalar never sees the high lane
    tr  = (fl & maskIn) != '0;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expVal,
                            input logic [63:0] actVal);
    assert (actVal === expVal) else begin
      $display("Mismatch %s: expected %h, actual %h", name, expVal, actVal);
      errors++;
    end
  endtask

  task automatic readTrace(output bit ok);
    int          fd;
    int          got;
    string       line;
    logic [63:0] f[11];
    fd = $fopen("verification/divSqrtTrace.txt", "r");
    ok = fd != 0;
    if (ok) begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        if (got > 0 && line.getc(0) != "#") begin
          got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
          if (got == 11) begin
            opQ.push_back(f[0][opWidth-1:0]);
            loAQ.push_back(f[1][laneWidth-1:0]);
            loBQ.push_back(f[2][laneWidth-1:0]);
            hiAQ.push_back(f[3][laneWidth-1:0]);
            hiBQ.push_back(f[4][laneWidth-1:0]);
            tagQ.push_back(f[5][tagWidth-1:0]);
            maskQ.push_back(f[6][flagWidth-1:0]);
            flushQ.push_back(int'(f[7][31:0]));
            resQ.push_back(f[8]);
            flagsQ.push_back(f[9][flagWidth-1:0]);
            trapQ.push_back(f[10][0]);
          end
        end
      end
      $fclose(fd);
    end
    ok = ok && (opQ.size() > 0);
    traceLoaded = 1'b1;
  endtask

  // issue one op, stray en at cycle 2, optional flush, then check the outcome
  task automatic runOp(
    input string                name,
    input logic [opWidth-1:0]   opIn,
    input logic [laneWidth-1:0] aLo,
    input logic [laneWidth-1:0] bLo,
    input logic [laneWidth-1:0] aHi,
    input logic [laneWidth-1:0] bHi,
    input logic [tagWidth-1:0]  tagIn,
    input logic [flagWidth-1:0] maskIn,
    input int                   flushAfter,
    input bit                   fromTrace,
    input logic [resWidth-1:0]  traceRes,
    input logic [flagWidth-1:0] traceFlags,
    input logic                 traceTrap
  );
    int                   cycles;
    int                   expLat;
    bit                   seen;
    logic [resWidth-1:0]  modelRes;
    logic [flagWidth-1:0] modelFlags;
    logic                 modelTrap;
    unitModel(opIn, aLo, bLo, aHi, bHi, maskIn, modelRes, modelFlags, modelTrap);
    expLat = (opIn == opSqrtS || opIn == opSqrtP) ? sqrtLatency : divLatency;
    @(negedge clk);
    en       = 1'b1;
    op       = opIn;
    loA      = aLo;
    loB      = bLo;
    hiA      = aHi;
    hiB      = bHi;
    tag      = tagIn;
    trapMask = maskIn;
    @(posedge clk); // accepting edge
    @(negedge clk);
    en = 1'b0;
    assert (busy === 1'b1) else begin
      $display("%s: busy did not rise after the op was issued", name);
      errors++;
    end
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < expLat + ((flushAfter != 0) ? 2 : 4)) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      en    = 1'b0;
      flush = 1'b0;
      if (outEn) begin
        seen = 1'b1;
      end else if (cycles == 2) begin
        en  = 1'b1; // must be dropped while busy
        op  = op ^ 2'b01;
        tag = ~tag;
      end else if (flushAfter != 0 && cycles == flushAfter) begin
        flush = 1'b1;
      end
      if (flushAfter != 0 && cycles == flushAfter + 1) begin
        assert (busy === 1'b0) else begin
          $display("%s: busy still high the cycle after flush", name);
          errors++;
        end
      end
    end
    if (flushAfter != 0) begin
      assert (!seen) else begin
        $display("%s: outEn was raised for a flushed op", name);
        errors++;
      end
    end else begin
      assert (seen) else begin
        $display("%s: no outEn within %0d cycles of issue", name, cycles);
        errors++;
      end
      if (seen) begin
        checkValue({name, " latency"}, 64'(expLat), 64'(cycles));
        checkValue({name, " tag"}, 64'(tagIn), 64'(outTag));
        checkValue({name, " model result"}, modelRes, result);
        checkValue({name, " model flags"}, 64'(modelFlags), 64'(flags));
        checkValue({name, " model trap"}, 64'(modelTrap), 64'(trap));
        if (fromTrace) begin
          checkValue({name, " result"}, traceRes, result);
          checkValue({name, " flags"}, 64'(traceFlags), 64'(flags));
          checkValue({name, " trap"}, 64'(traceTrap), 64'(trap));
        end
      end
    end
  endtask

  task automatic runAll();
    logic [31:0] r[6];
    int          seed;
    seed = 82;
    repeat (2) @(posedge clk); // reset held 2 cycles
    @(negedge clk);
    rst = 1'b0;
    checkValue("reset result", '0, result);
    checkValue("reset status", '0, 64'({busy, outEn, trap, flags, outTag}));
    for (int i = 0; i < opQ.size(); i++) begin
      runOp($sformatf("trace %0d", i + 1), opQ[i], loAQ[i], loBQ[i], hiAQ[i], hiBQ[i],
            tagQ[i], maskQ[i], flushQ[i], 1'b1, resQ[i], flagsQ[i], trapQ[i]);
    end
    for (int i = 0; i < randOps; i++) begin
      foreach (r[k]) r[k] = $random(seed);
      // narrow divisors so quotients are not mostly zero
      runOp($sformatf("random %0d", i + 1), r[0][1:0], r[1], {16'd0, r[2][15:0]}, r[3],
            {24'd0, r[4][7:0]}, r[5][5:0], r[5][7:6], 0, 1'b0, '0, '0, 1'b0);
    end
  endtask

  initial begin
    bit traceOk;
    clk      = 1'b0;
    rst      = 1'b1;
    flush    = 1'b0;
    en       = 1'b0;
    op       = opDivS;
    tag      = '0;
    loA      = '0;
    loB      = '0;
    hiA      = '0;
    hiB      = '0;
    trapMask = '0;
    readTrace(traceOk);
    if (!traceOk) begin
      $display("Could not read any operation from the trace file");
      $display("Simulation failed");
      $finish;
    end else begin
      runAll();
      $display("Error count: %0d check errors, %0d assertion failures", errors,
               divSqrtUnit_inst.sva.assertFails);
      if (errors == 0 && divSqrtUnit_inst.sva.assertFails == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // watchdog, budget grows with the number of ops
  initial begin
    int budget;
    wait (traceLoaded);
    budget = (opQ.size() + randOps) * (divLatency + 4) + 20;
    repeat (budget) @(posedge clk);
    $display("Timeout: the ops did not finish within %0d cycles", budget);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* verification/divSqrtUnit_sva.sv */
`timescale 1ns/10ps

module divSqrtUnit_sva (
  input logic clk,
  input logic rst,
  input logic flush,
  input logic busy,
  input logic outEn,
  input logic trap
);

  int assertFails = 0; // failed assertion count

  outEnPulse: assert property (@(posedge clk) disable iff (rst) outEn |=> !outEn)
    else begin
      $error("outEn was high on two consecutive cycles");
      assertFails++;
    end

  // busy covers the outEn cycle, then drops
  busyDrop: assert property (@(posedge clk) disable iff (rst) outEn |=> !busy)
    else begin
      $error("busy still high in the cycle after outEn");
      assertFails++;
    end

  trapWithOut: assert property (@(posedge clk) disable iff (rst) trap |-> outEn)
    else begin
      $error("trap raised without outEn");
      assertFails++;
    end

  flushIdle: assert property (@(posedge clk) disable iff (rst) flush |=> !busy)
    else begin
      $error("busy still high after flush");
      assertFails++;
    end

  // nothing pending once idle, so no late result
  idleNoOut: assert property (@(posedge clk) disable iff (rst) !busy |=> !outEn)
    else begin
      $error("outEn raised while the unit was idle");
      assertFails++;
    end

endmodule

/* design/divSqrtUnit.sv */
`timescale 1ns/10ps

module divSqrtUnit
  import divSqrtOpPkg::*;
  import divSqrtDataPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 en,
  input  logic [opWidth-1:0]   op,
  input  logic [tagWidth-1:0]  tag,
  input  logic [laneWidth-1:0] loA,
  input  logic [laneWidth-1:0] loB,
  input  logic [laneWidth-1:0] hiA,
  input  logic [laneWidth-1:0] hiB,
  input  logic [flagWidth-1:0] trapMask,
  output logic                 busy,
  output logic                 outEn,
  output logic [resWidth-1:0]  result,
  output logic [tagWidth-1:0]  outTag,
  output logic [flagWidth-1:0] flags,
  output logic                 trap
);

  logic                 startLo;
  logic                 startHi;
  logic                 isSqrt;
  logic                 loDone;
  logic                 hiDone;
  logic [laneWidth-1:0] loQuot;
  logic [laneWidth-1:0] loRem;
  logic [laneWidth-1:0] hiQuot;
  logic [flagWidth-1:0] loFlags;
  logic [flagWidth-1:0] hiFlags;

  divSqrtLane loLane (
    .clk(clk), .rst(rst), .flush(flush),
    .start(startLo), .isSqrt(isSqrt), .a(loA), .b(loB),
    .done(loDone), .quot(loQuot), .rem(loRem), .laneFlags(loFlags)
  );

  // packed results carry quotients only
  divSqrtLane hiLane (
    .clk(clk), .rst(rst), .flush(flush),
    .start(startHi), .isSqrt(isSqrt), .a(hiA), .b(hiB),
    .done(hiDone), .quot(hiQuot), .rem(), .laneFlags(hiFlags)
  );

  divSqrtCombine combine (
    .clk(clk), .rst(rst), .flush(flush),
    .en(en), .op(op), .tag(tag), .trapMask(trapMask),
    .loDone(loDone), .hiDone(hiDone),
    .loQuot(loQuot), .loRem(loRem), .hiQuot(hiQuot),
    .loFlags(loFlags), .hiFlags(hiFlags),
    .startLo(startLo), .startHi(startHi), .isSqrt(isSqrt), .busy(busy),
    .outEn(outEn), .result(result), .outTag(outTag), .flags(flags), .trap(trap)
  );

endmodule

/* design/divSqrtCombine.sv */
`timescale 1ns/10ps

module divSqrtCombine
  import divSqrtOpPkg::*;
  import divSqrtDataPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 en,
  input  logic [opWidth-1:0]   op,
  input  logic [tagWidth-1:0]  tag,
  input  logic [flagWidth-1:0] trapMask,
  input  logic                 loDone,
  input  logic                 hiDone,
  input  logic [laneWidth-1:0] loQuot,
  input  logic [laneWidth-1:0] loRem,
  input  logic [laneWidth-1:0] hiQuot,
  input  logic [flagWidth-1:0] loFlags,
  input  logic [flagWidth-1:0] hiFlags,
  output logic                 startLo,
  output logic                 startHi,
  output logic                 isSqrt,
  output logic                 busy,
  output logic                 outEn,
  output logic [resWidth-1:0]  result,
  output logic [tagWidth-1:0]  outTag,
  output logic [flagWidth-1:0] flags,
  output logic                 trap
);

  logic [opWidth-1:0]   opReg;   // op in flight
  logic [tagWidth-1:0]  tagReg;
  logic                 accept;
  logic                 isPacked;
  logic                 finish;
  logic [flagWidth-1:0] mergedFlags;
  logic [resWidth-1:0]  nextResult;

  assign accept   = en && !busy && !flush; // en while busy is dropped
  assign isPacked = opReg[opPackedBit];
  assign isSqrt   = opReg[opSqrtBit];      // lanes sample this with their start

  // both lanes of a packed op end on the same cycle
  assign finish = busy && loDone && (hiDone || !isPacked) && !flush;

  always_comb begin
    if (isPacked) begin
      nextResult  = {hiQuot, loQuot};
      mergedFlags = loFlags | hiFlags;
    end else begin
      nextResult  = {loRem, loQuot}; // scalar keeps the remainder
      mergedFlags = loFlags;         // high lane did not run
    end
  end

  // issue side
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      busy    <= 1'b0;
      startLo <= 1'b0;
      startHi <= 1'b0;
    end else begin
      startLo <= accept;
      startHi <= accept && op[opPackedBit];
      if (accept) begin
        busy <= 1'b1;
      end else if (outEn) begin
        busy <= 1'b0; // stays up through the outEn cycle
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opReg  <= op;
      tagReg <= tag;
    end
  end

  // outcome register, held until the next outEn
  always_ff @(posedge clk) begin
    if (rst) begin
      outEn  <= 1'b0;
      trap   <= 1'b0;
      result <= '0;
      outTag <= '0;
      flags  <= '0;
    end else begin
      outEn <= finish;
      trap  <= finish && ((mergedFlags & trapMask) != '0);
      if (finish) begin
        result <= nextResult;
        outTag <= tagReg;
        flags  <= mergedFlags;
      end
    end
  end

endmodule

/* design/divSqrtLane.sv */
`timescale 1ns/10ps

module divSqrtLane
  import divSqrtOpPkg::*;
  import divSqrtDataPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 start,
  input  logic                 isSqrt,
  input  logic [laneWidth-1:0] a,
  input  logic [laneWidth-1:0] b,
  output logic                 done,
  output logic [laneWidth-1:0] quot,
  output logic [laneWidth-1:0] rem,
  output logic [flagWidth-1:0] laneFlags
);

  logic                 sqrtMode;  // latched on load
  logic [iterWidth-1:0] count;     // iterations left, zero when idle
  logic [laneWidth-1:0] acc;       // partial remainder
  logic [laneWidth-1:0] work;      // dividend in, quotient out / radicand bits
  logic [laneWidth-1:0] divisor;
  logic [rootWidth-1:0] root;

  // divide step
  logic [laneWidth:0]   divShift;
  logic [laneWidth-1:0] divDiff;
  logic                 divFits;

  // square root step
  logic [laneWidth-1:0] sqrtShift;
  logic [laneWidth-1:0] sqrtTrial;
  logic [laneWidth-1:0] sqrtDiff;
  logic                 sqrtFits;

  always_comb begin
    // next dividend bit shifted in with one spare bit for the compare
    divShift = {acc, work[laneWidth-1]};
    divFits  = divShift >= {1'b0, divisor};
    divDiff  = divShift[laneWidth-1:0] - divisor; // only used when it fits
  end

  always_comb begin
    // acc stays below 2*root+1 so the top bits are free to shift into
    sqrtShift = {acc[laneWidth-3:0], work[laneWidth-1:laneWidth-2]};
    sqrtTrial = {{(laneWidth-rootWidth-2){1'b0}}, root, 2'b01}; // 4*root + 1
    sqrtFits  = sqrtShift >= sqrtTrial;
    sqrtDiff  = sqrtShift - sqrtTrial;
  end

  // iteration count and done pulse
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      count <= '0;
      done  <= 1'b0;
    end else if (start) begin
      count <= isSqrt ? iterWidth'(sqrtIters) : iterWidth'(divIters);
      done  <= 1'b0;
    end else if (count != '0) begin
      count <= count - 1'b1;
      done  <= count == iterWidth'(1); // last step lands this edge
    end else begin
      done <= 1'b0;
    end
  end

  // operand and partial result registers
  always_ff @(posedge clk) begin
    if (start) begin
      sqrtMode <= isSqrt;
      acc      <= '0;
      work     <= a;
      divisor  <= b;
      root     <= '0;
    end else if (count != '0) begin
      if (sqrtMode) begin
        work <= {work[laneWidth-3:0], 2'b00};
        if (sqrtFits) begin
          acc  <= sqrtDiff;
          root <= {root[rootWidth-2:0], 1'b1};
        end else begin
          acc  <= sqrtShift;
          root <= {root[rootWidth-2:0], 1'b0};
        end
      end else begin
        // restoring step keeps the shifted value when the divisor does not fit
        if (divFits) begin
          acc  <= divDiff;
          work <= {work[laneWidth-2:0], 1'b1};
        end else begin
          acc  <= divShift[laneWidth-1:0];
          work <= {work[laneWidth-2:0], 1'b0};
        end
      end
    end
  end

  // zero divisor always fits, so quotient ends all ones and acc ends as the dividend
  assign quot = sqrtMode ? {{(laneWidth-rootWidth){1'b0}}, root} : work;
  assign rem  = acc;

  always_comb begin
    laneFlags              = '0;
    laneFlags[flagDivZero] = !sqrtMode && (divisor == '0);
    laneFlags[flagInexact] = rem != '0; // a - root^2 for sqrt
  end

endmodule

/* design/divSqrtDataPkg.sv */
package divSqrtDataPkg;

  // one lane operand, quotient or remainder
  localparam int laneWidth = 32;

  // unit result, two lane words side by side
  localparam int resWidth = 2 * laneWidth;

  // floor root of a laneWidth radicand
  localparam int rootWidth = laneWidth / 2;

  // destination tag carried through with the op
  localparam int tagWidth = 6;

  // status flags, one bit each
  localparam int flagWidth = 2;
  localparam int flagDivZero = 0; // divisor was zero
  localparam int flagInexact = 1; // remainder nonzero

endpackage

/* design/divSqrtOpPkg.sv */
package divSqrtOpPkg;

  // opcode field, bit 0 picks sqrt and bit 1 picks packed
  localparam int opWidth = 2;
  localparam int opSqrtBit = 0;
  localparam int opPackedBit = 1;

  localparam logic [opWidth-1:0] opDivS  = 2'b00; // scalar divide, low lane only
  localparam logic [opWidth-1:0] opSqrtS = 2'b01; // scalar square root
  localparam logic [opWidth-1:0] opDivP  = 2'b10; // two independent divides
  localparam logic [opWidth-1:0] opSqrtP = 2'b11; // two independent roots

  // one quotient bit per iteration
  localparam int divIters = 32;
  // two radicand bits per iteration
  localparam int sqrtIters = 16;

  // lane iteration counter must hold the larger count
  localparam int iterWidth = $clog2(divIters + 1);

  // issue edge to the edge after which outEn is high
  // start register, load, iterations, then the result register
  localparam int divLatency = 34;
  localparam int sqrtLatency = 18;

endpackage
